// File: design/control_strobe_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_settings.svh"

module control_strobe_gen
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire ctrl_pkg::phase_t       phase,
    input  wire ctrl_pkg::instr_class_t instr_class,
    input  wire ctrl_pkg::access_size_t access_size,
    input  wire logic                   comparator,
    output logic                        ir_en,
    output logic                        pc_en,
    output logic [`SEL_W-1:0]           pc_select,
    output logic                        alu_src,
    output logic                        reg_write,
    output logic [`SEL_W-1:0]           mem_to_reg,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic                        is_byte,
    output logic                        is_half,
    output logic                        is_word,
    output logic                        instr_done
);

    import ctrl_pkg::*;

    logic             ir_en_d;
    logic             pc_en_d;
    logic [`SEL_W-1:0] pc_select_d;
    logic             alu_src_d;
    logic             reg_write_d;
    logic [`SEL_W-1:0] mem_to_reg_d;
    logic             mem_read_d;
    logic             mem_write_d;
    logic             is_byte_d;
    logic             is_half_d;
    logic             is_word_d;
    logic             instr_done_d;

    logic             in_execute;
    logic             is_mem_op;

    assign in_execute = (phase == EX_SETUP) || (phase == EX_ACCESS) ||
                        (phase == EX_WRITEBACK);
    assign is_mem_op  = (instr_class == CLS_LOAD) || (instr_class == CLS_STORE);

    ////////////////////////////////////////////////////////////////////////
    // Strobes for the coming cycle
    ////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        ir_en_d      = 1'b0;
        pc_en_d      = 1'b0;
        pc_select_d  = `PC_SEL_PLUS4;
        alu_src_d    = 1'b0;
        reg_write_d  = 1'b0;
        mem_to_reg_d = `WB_SEL_ALU;
        mem_read_d   = 1'b0;
        mem_write_d  = 1'b0;
        is_byte_d    = 1'b0;
        is_half_d    = 1'b0;
        is_word_d    = 1'b0;
        instr_done_d = 1'b0;

        // Operand and write-back selects hold across all of execute
        if (in_execute)
        begin
            alu_src_d = (instr_class == CLS_I) || (instr_class == CLS_JALR) || is_mem_op;

            case (instr_class)
                CLS_LOAD:          mem_to_reg_d = `WB_SEL_MEM;
                CLS_JAL, CLS_JALR: mem_to_reg_d = `WB_SEL_PC4;   // Link address
                default:           mem_to_reg_d = `WB_SEL_ALU;
            endcase
        end

        case (phase)
            FETCH:     ir_en_d = 1'b1;
            PC_UPDATE: pc_en_d = 1'b1;      // Select stays at PC+4

            EX_ACCESS:
            begin
                mem_read_d  = (instr_class == CLS_LOAD);
                mem_write_d = (instr_class == CLS_STORE);
                is_byte_d   = is_mem_op && (access_size == SIZE_BYTE);
                is_half_d   = is_mem_op && (access_size == SIZE_HALF);
                is_word_d   = is_mem_op && (access_size == SIZE_WORD);
            end

            EX_WRITEBACK:
            begin
                case (instr_class)
                    CLS_R, CLS_I, CLS_LOAD: reg_write_d = 1'b1;
                    CLS_BRANCH:
                    begin
                        pc_en_d     = comparator;   // Taken branch only
                        pc_select_d = comparator ? `PC_SEL_BRANCH : `PC_SEL_PLUS4;
                    end
                    CLS_JAL:
                    begin
                        reg_write_d = 1'b1;
                        pc_en_d     = 1'b1;
                        pc_select_d = `PC_SEL_JAL;
                    end
                    CLS_JALR:
                    begin
                        reg_write_d = 1'b1;
                        pc_en_d     = 1'b1;
                        pc_select_d = `PC_SEL_JALR;
                    end
                    default: ;                      // Store and illegal stay quiet
                endcase
            end

            EX_CLOSE:  instr_done_d = 1'b1;
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ir_en      <= 1'b0;
            pc_en      <= 1'b0;
            pc_select  <= '0;
            alu_src    <= 1'b0;
            reg_write  <= 1'b0;
            mem_to_reg <= '0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            is_byte    <= 1'b0;
            is_half    <= 1'b0;
            is_word    <= 1'b0;
            instr_done <= 1'b0;
        end
        else
        begin
            ir_en      <= ir_en_d;
            pc_en      <= pc_en_d;
            pc_select  <= pc_select_d;
            alu_src    <= alu_src_d;
            reg_write  <= reg_write_d;
            mem_to_reg <= mem_to_reg_d;
            mem_read   <= mem_read_d;
            mem_write  <= mem_write_d;
            is_byte    <= is_byte_d;
            is_half    <= is_half_d;
            is_word    <= is_word_d;
            instr_done <= instr_done_d;
        end
    end

endmodule

`default_nettype wire

// File: design/ctrl_pkg.sv
`default_nettype none

`include "ctrl_settings.svh"

package ctrl_pkg;

    // One instruction walks FETCH through EX_CLOSE, then back to IDLE
    typedef enum logic [`PHASE_W-1:0]
    {
        IDLE,
        FETCH,
        PC_UPDATE,
        DECODE,
        EX_SETUP,
        EX_ACCESS,
        EX_WRITEBACK,
        EX_CLOSE
    } phase_t;

    typedef enum logic [`CLASS_W-1:0]
    {
        CLS_R,
        CLS_I,          // Also LUI and AUIPC
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_ILLEGAL
    } instr_class_t;

    // Signed and unsigned loads share a size
    typedef enum logic [`SIZE_W-1:0]
    {
        SIZE_NONE,
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } access_size_t;

endpackage

`default_nettype wire

// File: design/ctrl_settings.svh
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////////////////////
`define OPCODE_W        7
`define FUNC3_W         3
`define SEL_W           2
`define PHASE_W         3       // Sequencer state
`define CLASS_W         3       // Decoded instruction class
`define SIZE_W          2       // Memory access size

////////////////////////////////////////////////////////////////////////////
// RV32I major opcodes
////////////////////////////////////////////////////////////////////////////
`define OPC_RTYPE       7'b0110011
`define OPC_ITYPE       7'b0010011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111

// Load and store width field
`define F3_BYTE         3'b000
`define F3_HALF         3'b001
`define F3_WORD         3'b010
`define F3_BYTE_U       3'b100  // Loads only
`define F3_HALF_U       3'b101  // Loads only

////////////////////////////////////////////////////////////////////////////
// Datapath select codes
////////////////////////////////////////////////////////////////////////////
`define PC_SEL_PLUS4    2'd0
`define PC_SEL_BRANCH   2'd1
`define PC_SEL_JAL      2'd2
`define PC_SEL_JALR     2'd3

// Register file write-back source
`define WB_SEL_ALU      2'd0
`define WB_SEL_MEM      2'd1
`define WB_SEL_PC4      2'd2

`endif

// File: design/opcode_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_settings.svh"

module opcode_decoder
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [`OPCODE_W-1:0]   opcode,
    input  wire logic [`FUNC3_W-1:0]    func3,
    output ctrl_pkg::instr_class_t      instr_class,
    output ctrl_pkg::access_size_t      access_size
);

    import ctrl_pkg::*;

    instr_class_t class_d;
    access_size_t size_d;

    ////////////////////////////////////////////////////////////////////////
    // Classification
    ////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        class_d = CLS_ILLEGAL;
        size_d  = SIZE_NONE;

        case (opcode)
            `OPC_RTYPE:  class_d = CLS_R;
            `OPC_ITYPE,
            `OPC_LUI,
            `OPC_AUIPC:  class_d = CLS_I;   // All three write an ALU result
            `OPC_BRANCH: class_d = CLS_BRANCH;
            `OPC_JAL:    class_d = CLS_JAL;
            `OPC_JALR:   class_d = CLS_JALR;

            `OPC_LOAD:
            begin
                class_d = CLS_LOAD;
                case (func3)
                    `F3_BYTE, `F3_BYTE_U: size_d = SIZE_BYTE;
                    `F3_HALF, `F3_HALF_U: size_d = SIZE_HALF;
                    `F3_WORD:             size_d = SIZE_WORD;
                    default:              class_d = CLS_ILLEGAL;
                endcase
            end

            // Stores have no unsigned forms
            `OPC_STORE:
            begin
                class_d = CLS_STORE;
                case (func3)
                    `F3_BYTE: size_d = SIZE_BYTE;
                    `F3_HALF: size_d = SIZE_HALF;
                    `F3_WORD: size_d = SIZE_WORD;
                    default:  class_d = CLS_ILLEGAL;
                endcase
            end

            default:     class_d = CLS_ILLEGAL;
        endcase
    end

    // Registered every cycle and valid one cycle after the IR settles
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            instr_class <= CLS_ILLEGAL;
            access_size <= SIZE_NONE;
        end
        else
        begin
            instr_class <= class_d;
            access_size <= size_d;
        end
    end

endmodule

`default_nettype wire

// File: design/phase_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module phase_sequencer
(
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             go,
    output ctrl_pkg::phase_t      phase
);

    import ctrl_pkg::*;

    phase_t next_phase;

    ////////////////////////////////////////////////////////////////////////
    // Next phase
    ////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (phase)
            IDLE:         next_phase = go ? FETCH : IDLE;   // Go only matters here
            FETCH:        next_phase = PC_UPDATE;
            PC_UPDATE:    next_phase = DECODE;
            DECODE:       next_phase = EX_SETUP;
            EX_SETUP:     next_phase = EX_ACCESS;
            EX_ACCESS:    next_phase = EX_WRITEBACK;
            EX_WRITEBACK: next_phase = EX_CLOSE;
            EX_CLOSE:     next_phase = IDLE;
            default:      next_phase = IDLE;
        endcase
    end

    // The class never stretches execute
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase <= IDLE;
        end
        else
        begin
            phase <= next_phase;
        end
    end

endmodule

`default_nettype wire

// File: design/riscv_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_settings.svh"

module riscv_ctrl_top
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   go,
    input  wire logic [`OPCODE_W-1:0]   opcode,
    input  wire logic [`FUNC3_W-1:0]    func3,
    input  wire logic                   comparator,
    output logic                        ir_en,
    output logic                        pc_en,
    output logic [`SEL_W-1:0]           pc_select,
    output logic                        alu_src,
    output logic                        reg_write,
    output logic [`SEL_W-1:0]           mem_to_reg,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic                        is_byte,
    output logic                        is_half,
    output logic                        is_word,
    output logic                        instr_done
);

    import ctrl_pkg::*;

    phase_t       phase;
    instr_class_t instr_class;
    access_size_t access_size;

    ////////////////////////////////////////////////////////////////////////
    // Sequencer, decoder and strobe registers
    ////////////////////////////////////////////////////////////////////////
    phase_sequencer phase_sequencer_inst
    (
        .clk         (clk),
        .reset       (reset),
        .go          (go),
        .phase       (phase)
    );

    // Opcode and func3 come straight from the instruction register
    opcode_decoder opcode_decoder_inst
    (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .func3       (func3),
        .instr_class (instr_class),
        .access_size (access_size)
    );

    control_strobe_gen control_strobe_gen_inst
    (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instr_class (instr_class),
        .access_size (access_size),
        .comparator  (comparator),
        .ir_en       (ir_en),
        .pc_en       (pc_en),
        .pc_select   (pc_select),
        .alu_src     (alu_src),
        .reg_write   (reg_write),
        .mem_to_reg  (mem_to_reg),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .is_byte     (is_byte),
        .is_half     (is_half),
        .is_word     (is_word),
        .instr_done  (instr_done)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the control unit testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f tb.f --top-module tb_ctrl -o tb_ctrl \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_ctrl > sim.log 2>&1
cat sim.log

grep -q "^=== PASS ===$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: sim/tb_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_settings.svh"

module tb_ctrl;

    import ctrl_pkg::*;

    localparam int NUM_INSTR      = 300;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12 + 50;

    logic                 clk;
    logic                 reset      = 1'b1;
    logic                 go         = 1'b0;
    logic [`OPCODE_W-1:0] opcode     = '0;
    logic [`FUNC3_W-1:0]  func3      = '0;
    logic                 comparator = 1'b0;
    logic                 ir_en, pc_en, alu_src, reg_write, mem_read, mem_write;
    logic                 is_byte, is_half, is_word, instr_done;
    logic [`SEL_W-1:0]    pc_select, mem_to_reg;

    logic                 exp_ir_en, exp_pc_en, exp_alu_src, exp_reg_write;
    logic                 exp_mem_read, exp_mem_write, exp_instr_done;
    logic                 exp_is_byte, exp_is_half, exp_is_word;
    logic [`SEL_W-1:0]    exp_pc_select, exp_mem_to_reg;

    logic [31:0]          rng_state   = 32'h224b;
    int                   stage       = 0;  // Model phase with 0 for idle and 1 to 7 active
    int                   cur_k       = 0;  // Table row for the outputs of this cycle
    int                   hold_low    = 5;  // Cycles left with go low
    int                   issued      = 0;
    int                   done_count  = 0;
    int                   cycle_count = 0;

    riscv_ctrl_top riscv_ctrl_top_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        wait (done_count == NUM_INSTR);
        repeat (4) @(negedge clk);          // Outputs must stay quiet with go low
        $display("=== PASS ===");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [`OPCODE_W-1:0] legal_opcode(input logic [3:0] n);
        case (n)
            4'd0:    return `OPC_RTYPE;
            4'd1:    return `OPC_ITYPE;
            4'd2:    return `OPC_LOAD;
            4'd3:    return `OPC_STORE;
            4'd4:    return `OPC_BRANCH;
            4'd5:    return `OPC_JAL;
            4'd6:    return `OPC_JALR;
            4'd7:    return `OPC_LUI;
            default: return `OPC_AUIPC;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic instr_class_t expected_class(input logic [`OPCODE_W-1:0] opc,
                                                    input logic [`FUNC3_W-1:0] f3);
        if (opc == `OPC_RTYPE)
            return CLS_R;
        if (opc == `OPC_ITYPE || opc == `OPC_LUI || opc == `OPC_AUIPC)
            return CLS_I;
        if (opc == `OPC_LOAD)
            return (f3 == 3'd3 || f3 > 3'd5) ? CLS_ILLEGAL : CLS_LOAD;
        if (opc == `OPC_STORE)
            return (f3 <= 3'd2) ? CLS_STORE : CLS_ILLEGAL;
        if (opc == `OPC_BRANCH)
            return CLS_BRANCH;
        if (opc == `OPC_JAL)
            return CLS_JAL;
        if (opc == `OPC_JALR)
            return CLS_JALR;
        return CLS_ILLEGAL;
    endfunction

    function automatic access_size_t expected_size(input instr_class_t cls,
                                                   input logic [`FUNC3_W-1:0] f3);
        if (cls != CLS_LOAD && cls != CLS_STORE)
            return SIZE_NONE;
        case (f3[1:0])                      // Unsigned loads only differ in bit 2
            2'd0:    return SIZE_BYTE;
            2'd1:    return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    task automatic predict_outputs;
        instr_class_t cls;
        access_size_t size;
        cls            = expected_class(opcode, func3);
        size           = expected_size(cls, func3);
        exp_ir_en      = (cur_k == 1);
        exp_pc_en      = (cur_k == 2);
        exp_pc_select  = `PC_SEL_PLUS4;
        exp_alu_src    = 1'b0;
        exp_reg_write  = 1'b0;
        exp_mem_to_reg = `WB_SEL_ALU;
        exp_mem_read   = (cur_k == 5) && (cls == CLS_LOAD);
        exp_mem_write  = (cur_k == 5) && (cls == CLS_STORE);
        exp_is_byte    = (cur_k == 5) && (size == SIZE_BYTE);
        exp_is_half    = (cur_k == 5) && (size == SIZE_HALF);
        exp_is_word    = (cur_k == 5) && (size == SIZE_WORD);
        exp_instr_done = (cur_k == 7);

        // Class selects across the three execute cycles
        if (cur_k >= 4 && cur_k <= 6)
        begin
            exp_alu_src = cls inside {CLS_I, CLS_LOAD, CLS_STORE, CLS_JALR};
            if (cls == CLS_LOAD)
                exp_mem_to_reg = `WB_SEL_MEM;
            else if (cls == CLS_JAL || cls == CLS_JALR)
                exp_mem_to_reg = `WB_SEL_PC4;
        end

        if (cur_k == 6)
        begin
            exp_reg_write = cls inside {CLS_R, CLS_I, CLS_LOAD, CLS_JAL, CLS_JALR};
            exp_pc_en     = (cls == CLS_BRANCH && comparator) || cls == CLS_JAL ||
                            cls == CLS_JALR;
            if (cls == CLS_BRANCH && comparator)
                exp_pc_select = `PC_SEL_BRANCH;
            else if (cls == CLS_JAL)
                exp_pc_select = `PC_SEL_JAL;
            else if (cls == CLS_JALR)
                exp_pc_select = `PC_SEL_JALR;
        end
    endtask

    task automatic check_strobe(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_select(input string name, input logic [`SEL_W-1:0] actual,
                                input logic [`SEL_W-1:0] expected);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and model state, on the rising edge
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        if (!reset)
        begin
            cur_k <= stage;
            if (stage == 0)
                stage <= go ? 1 : 0;        // Go only counts while idle
            else if (stage == 7)
                stage <= 0;
            else
                stage <= stage + 1;

            // New instruction once the IR has loaded
            if (ir_en && issued < NUM_INSTR)
            begin
                rng_state = xorshift(rng_state);
                if (rng_state % 32'd10 < 32'd8)
                    opcode <= legal_opcode(rng_state[19:16] % 4'd9);
                else
                    opcode <= rng_state[26:20];
                func3      <= rng_state[10:8];
                comparator <= rng_state[12];
                issued     <= issued + 1;
            end

            if (hold_low > 0)
            begin
                hold_low <= hold_low - 1;
                if (hold_low == 1)
                    go <= 1'b1;
            end
            else if (stage == 7)            // Phase heads back to IDLE
            begin
                rng_state = xorshift(rng_state);
                if (issued >= NUM_INSTR)
                    go <= 1'b0;
                else if (rng_state[1:0] == 2'd0)
                begin
                    go       <= 1'b0;
                    hold_low <= int'(rng_state[9:4] % 6'd3) + 1;
                end
            end
        end
    end

    // Outputs are compared mid-cycle
    always @(negedge clk)
    begin
        predict_outputs();
        check_strobe("ir_en", ir_en, exp_ir_en);
        check_strobe("pc_en", pc_en, exp_pc_en);
        check_select("pc_select", pc_select, exp_pc_select);
        check_strobe("alu_src", alu_src, exp_alu_src);
        check_strobe("reg_write", reg_write, exp_reg_write);
        check_select("mem_to_reg", mem_to_reg, exp_mem_to_reg);
        check_strobe("mem_read", mem_read, exp_mem_read);
        check_strobe("mem_write", mem_write, exp_mem_write);
        check_strobe("is_byte", is_byte, exp_is_byte);
        check_strobe("is_half", is_half, exp_is_half);
        check_strobe("is_word", is_word, exp_is_word);
        check_strobe("instr_done", instr_done, exp_instr_done);
        if (exp_instr_done)
            done_count = done_count + 1;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: only %0d of %0d instructions completed in %0d cycles",
                     done_count, NUM_INSTR, cycle_count);
            $display("=== FAIL ===");
            $fatal(1, "Run did not finish in time");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/ctrl_pkg.sv
design/phase_sequencer.sv
design/opcode_decoder.sv
design/control_strobe_gen.sv
design/riscv_ctrl_top.sv
sim/tb_ctrl.sv
